// ==== Bender.yml ====
package:
  name: event_buffer

sources:
  - include_dirs:
      - src
    files:
      - src/buffer_pkg.sv
      - src/write_timing.sv
      - src/readout_sequencer.sv
      - src/channel_store.sv
      - src/event_buffer_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - testbench/event_buffer_checker.sv
      - testbench/event_buffer_tb.sv

// ==== files.f ====
+incdir+src
src/buffer_pkg.sv
src/write_timing.sv
src/readout_sequencer.sv
src/channel_store.sv
src/event_buffer_top.sv
testbench/event_buffer_checker.sv
testbench/event_buffer_tb.sv

// ==== src/buffer_defines.svh ====
`ifndef BUFFER_DEFINES_SVH
`define BUFFER_DEFINES_SVH

// number of channels, each with its own circular store
`define BUF_NCHAN 4

// samples packed into one memory word
`define BUF_NSAMP 6

// bits per sample
`define BUF_NBIT 12

// memory address width, the depth is 2**BUF_ADDRLEN words
`define BUF_ADDRLEN 10

// width of the request word; bits above BUF_ADDRLEN are ignored
// and the bottom two are forced to zero for alignment
`define BUF_ADDRBITS 12

// words read out per accepted request
`define BUF_RDLEN 24

// the memclk phase (0 to 3) in which a request can be taken
`define BUF_READOUT_PHASE 0

// clocks between neighboring channels on the read chain.
// this is set by the two register stages in each channel store
`define BUF_CHAN_STAGGER 2

`endif

// ==== src/buffer_pkg.sv ====
`include "buffer_defines.svh"

package buffer_pkg;

    // one digitizer sample, no sign interpretation here
    typedef logic [`BUF_NBIT-1:0] sample_t;

    // an address into one channel store
    typedef logic [`BUF_ADDRLEN-1:0] buf_addr_t;

    // one memory word seen two ways.
    // the memory only knows the flat vector, while the ports and
    // the testbench look at the individual samples
    typedef union packed {
        logic [`BUF_NSAMP*`BUF_NBIT-1:0] raw;
        sample_t [`BUF_NSAMP-1:0]        samples;
    } mem_word_u;

    // a read command travelling down the channel chain
    typedef struct packed {
        logic      en;
        buf_addr_t addr;
    } read_cmd_t;

    // one word per channel, channel 0 in the lowest slot
    typedef mem_word_u [`BUF_NCHAN-1:0] chan_words_t;

endpackage

// ==== src/channel_store.sv ====
`timescale 1ns/1ps
`include "buffer_defines.svh"

module channel_store (
    input  logic                  memclk,
    input  logic                  write_reset,
    input  buffer_pkg::buf_addr_t write_addr_i,
    input  buffer_pkg::mem_word_u word_i,
    input  buffer_pkg::read_cmd_t cmd_i,
    output buffer_pkg::read_cmd_t cmd_o,
    output buffer_pkg::mem_word_u word_o,
    output logic                  valid_o
);

    localparam int depth = 1 << `BUF_ADDRLEN;

    logic [`BUF_NSAMP*`BUF_NBIT-1:0] mem [depth];
    logic [`BUF_NSAMP*`BUF_NBIT-1:0] rd_q;
    buffer_pkg::mem_word_u           word_q;
    buffer_pkg::read_cmd_t           cmd_d1_q;
    buffer_pkg::read_cmd_t           cmd_d2_q;

    // write port runs every cycle.
    // the read sees the old contents when both hit the same address,
    // which is the word stored before this cycle's write
    always_ff @(posedge memclk) begin
        mem[write_addr_i] <= word_i.raw;
        if (cmd_i.en) begin
            rd_q <= mem[cmd_i.addr];
        end
    end

    // output register, second read stage
    always_ff @(posedge memclk) begin
        if (cmd_d1_q.en) begin
            word_q.raw <= rd_q;
        end
    end

    // the command follows the data through two stages.
    // its delayed enable is the valid for this channel, and the same
    // delayed command feeds the next channel, which staggers the chain
    always_ff @(posedge memclk) begin
        if (write_reset) begin
            cmd_d1_q.en <= 1'b0;
            cmd_d2_q.en <= 1'b0;
        end else begin
            cmd_d1_q.en <= cmd_i.en;
            cmd_d2_q.en <= cmd_d1_q.en;
        end
    end

    always_ff @(posedge memclk) begin
        cmd_d1_q.addr <= cmd_i.addr;
        cmd_d2_q.addr <= cmd_d1_q.addr;
    end

    assign cmd_o   = cmd_d2_q;
    assign word_o  = word_q;
    assign valid_o = cmd_d2_q.en;

endmodule

// ==== src/event_buffer_top.sv ====
`timescale 1ns/1ps
`include "buffer_defines.svh"

module event_buffer_top (
    input  logic                        memclk,
    input  logic                        write_reset,
    input  buffer_pkg::chan_words_t     dat_i,
    input  logic                        memclk_sync_i,
    input  logic [`BUF_ADDRBITS-1:0]    req_data_i,
    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    output logic                        begin_o,
    output buffer_pkg::chan_words_t     dat_o,
    output logic [`BUF_NCHAN-1:0]       dat_valid_o
);

    logic [3:0]            phase;
    buffer_pkg::buf_addr_t write_addr;

    // command chain, entry c feeds channel c.
    // the final entry is the tail of the chain and goes nowhere
    buffer_pkg::read_cmd_t cmd_chain [`BUF_NCHAN+1];

    write_timing u_timing (
        .memclk        (memclk),
        .write_reset   (write_reset),
        .memclk_sync_i (memclk_sync_i),
        .phase_o       (phase),
        .write_addr_o  (write_addr)
    );

    readout_sequencer u_sequencer (
        .memclk      (memclk),
        .write_reset (write_reset),
        .phase_i     (phase),
        .req_data_i  (req_data_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .begin_o     (begin_o),
        .cmd_o       (cmd_chain[0])
    );

    // every store writes at the shared pointer.
    // reads ripple down the chain two clocks per channel
    for (genvar c = 0; c < `BUF_NCHAN; c++) begin : g_chan
        channel_store u_store (
            .memclk       (memclk),
            .write_reset  (write_reset),
            .write_addr_i (write_addr),
            .word_i       (dat_i[c]),
            .cmd_i        (cmd_chain[c]),
            .cmd_o        (cmd_chain[c+1]),
            .word_o       (dat_o[c]),
            .valid_o      (dat_valid_o[c])
        );
    end

endmodule

// ==== src/readout_sequencer.sv ====
`timescale 1ns/1ps
`include "buffer_defines.svh"

module readout_sequencer (
    input  logic                          memclk,
    input  logic                          write_reset,
    input  logic [3:0]                    phase_i,
    input  logic [`BUF_ADDRBITS-1:0]      req_data_i,
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    output logic                          begin_o,
    output buffer_pkg::read_cmd_t         cmd_o
);

    localparam int rem_w = $clog2(`BUF_RDLEN);

    logic                  running_q;
    logic                  begin_q;
    logic                  cmd_en_q;
    logic [rem_w-1:0]      rem_q;
    buffer_pkg::buf_addr_t cmd_addr_q;
    logic                  ready;
    logic                  accept;
    logic                  last_cmd;

    // requests line up with one fixed phase so the readout timing
    // relative to the write side is always known
    assign ready    = phase_i[`BUF_READOUT_PHASE] && !running_q;
    assign accept   = req_valid_i && ready;
    assign last_cmd = cmd_en_q && (rem_q == '0);

    always_ff @(posedge memclk) begin
        if (write_reset) begin
            running_q <= 1'b0;
            begin_q   <= 1'b0;
            cmd_en_q  <= 1'b0;
            rem_q     <= '0;
        end else begin
            begin_q <= accept;

            // busy from acceptance through the last command
            if (accept) begin
                running_q <= 1'b1;
            end else if (last_cmd) begin
                running_q <= 1'b0;
            end

            // commands start the cycle after the begin pulse.
            // rem_q counts the commands still to come after this one
            if (begin_q) begin
                cmd_en_q <= 1'b1;
                rem_q    <= rem_w'(`BUF_RDLEN - 1);
            end else if (last_cmd) begin
                cmd_en_q <= 1'b0;
            end else if (cmd_en_q) begin
                rem_q <= rem_q - 1'b1;
            end
        end
    end

    // start address is forced onto a four word boundary.
    // it steps once per command and wraps with the address width
    always_ff @(posedge memclk) begin
        if (accept) begin
            cmd_addr_q <= {req_data_i[`BUF_ADDRLEN-1:2], 2'b00};
        end else if (cmd_en_q) begin
            cmd_addr_q <= cmd_addr_q + 1'b1;
        end
    end

    assign req_ready_o = ready;
    assign begin_o     = begin_q;
    assign cmd_o.en    = cmd_en_q;
    assign cmd_o.addr  = cmd_addr_q;

endmodule

// ==== src/write_timing.sv ====
`timescale 1ns/1ps
`include "buffer_defines.svh"

module write_timing (
    input  logic                  memclk,
    input  logic                  write_reset,
    input  logic                  memclk_sync_i,
    output logic [3:0]            phase_o,
    output buffer_pkg::buf_addr_t write_addr_o
);

    logic [3:0]            phase_q;
    buffer_pkg::buf_addr_t write_addr_q;

    // one-hot phase ring.
    // the sync pulse marks phase 0, so the cycle after it is phase 1.
    // bit 1 is loaded only from the sync input, which realigns the ring
    // on every pulse and keeps it all zero until the first one arrives
    always_ff @(posedge memclk) begin
        if (write_reset) begin
            phase_q <= 4'b0000;
        end else begin
            phase_q <= {phase_q[2:1], memclk_sync_i, phase_q[3]};
        end
    end

    // single write pointer shared by every channel store.
    // it sits at zero in the cycle after reset and wraps at the depth
    always_ff @(posedge memclk) begin
        if (write_reset) begin
            write_addr_q <= '0;
        end else begin
            write_addr_q <= write_addr_q + 1'b1;
        end
    end

    assign phase_o      = phase_q;
    assign write_addr_o = write_addr_q;

endmodule

// ==== testbench/event_buffer_checker.sv ====
`timescale 1ns/1ps
`include "buffer_defines.svh"

module event_buffer_checker (
    input logic                  memclk,
    input logic                  write_reset,
    input logic [3:0]            phase_i,
    input logic                  req_valid_i,
    input logic                  req_ready_i,
    input logic                  begin_i,
    input logic                  cmd_en_i,
    input logic [`BUF_NCHAN-1:0] dat_valid_i
);

    // begin cycle plus the RDLEN command cycles
    localparam int busy_len = `BUF_RDLEN + 1;

    int         fail_count = 0;
    logic [1:0] rst_hist;
    logic       rst_block;
    logic       accept;

    assign accept    = req_valid_i && req_ready_i;
    assign rst_block = write_reset || (|rst_hist);

    // the stagger compares values two clocks apart, so the history
    // has to be clean of reset for two cycles
    always_ff @(posedge memclk) begin
        rst_hist <= {rst_hist[0], write_reset};
    end

    a_ready_phase: assert property (@(posedge memclk)
        req_ready_i |-> phase_i[`BUF_READOUT_PHASE])
        else begin
            $error("request ready outside the readout phase");
            fail_count++;
        end

    a_ready_busy: assert property (@(posedge memclk) disable iff (rst_block)
        accept |=> !req_ready_i [*busy_len])
        else begin
            $error("request ready while a readout is running");
            fail_count++;
        end

    a_ready_cmd: assert property (@(posedge memclk) disable iff (rst_block)
        cmd_en_i |-> !req_ready_i)
        else begin
            $error("request ready during a channel 0 read command");
            fail_count++;
        end

    a_begin_after_accept: assert property (@(posedge memclk) disable iff (rst_block)
        accept |=> begin_i)
        else begin
            $error("no begin pulse after an accepted request");
            fail_count++;
        end

    a_begin_cause: assert property (@(posedge memclk) disable iff (rst_block)
        begin_i |-> $past(accept))
        else begin
            $error("begin pulse without an accepted request");
            fail_count++;
        end

    a_begin_width: assert property (@(posedge memclk) disable iff (rst_block)
        begin_i |=> !begin_i)
        else begin
            $error("begin pulse longer than one cycle");
            fail_count++;
        end

    a_begin_to_valid: assert property (@(posedge memclk) disable iff (rst_block)
        begin_i |-> ##3 dat_valid_i[0])
        else begin
            $error("channel 0 data not valid three cycles after begin");
            fail_count++;
        end

    // each channel repeats its neighbor's valid two clocks later
    for (genvar c = 1; c < `BUF_NCHAN; c++) begin : g_stagger
        a_stagger: assert property (@(posedge memclk) disable iff (rst_block)
            dat_valid_i[c] == $past(dat_valid_i[c-1], `BUF_CHAN_STAGGER))
            else begin
                $error("channel %0d valid does not follow channel %0d", c, c - 1);
                fail_count++;
            end
    end

    a_reset_quiet: assert property (@(posedge memclk)
        write_reset |=> (!req_ready_i && !begin_i && (dat_valid_i == '0)))
        else begin
            $error("outputs active during or right after reset");
            fail_count++;
        end

endmodule

// ==== testbench/event_buffer_tb.sv ====
`timescale 1ns/1ps
`include "buffer_defines.svh"

module event_buffer_tb;

    localparam int depth       = 1 << `BUF_ADDRLEN;
    localparam int margin      = `BUF_RDLEN + 2 * `BUF_NCHAN + 8;
    localparam int hi_bits     = `BUF_ADDRBITS - `BUF_ADDRLEN;
    localparam int clk_period  = 4;
    localparam int n_tests     = 6;
    localparam int test_cycles = 2 * 16 + 4 * (`BUF_RDLEN + 2 * `BUF_NCHAN + 32);

    logic                     memclk;
    logic                     write_reset;
    buffer_pkg::chan_words_t  dat_i;
    logic                     memclk_sync_i;
    logic [`BUF_ADDRBITS-1:0] req_data_i;
    logic                     req_valid_i;
    logic                     req_ready_o;
    logic                     begin_o;
    buffer_pkg::chan_words_t  dat_o;
    logic [`BUF_NCHAN-1:0]    dat_valid_o;

    // shadow copy of every channel store and its write pointer
    buffer_pkg::mem_word_u shadow [`BUF_NCHAN][depth];
    buffer_pkg::buf_addr_t wr_ptr;
    logic [31:0]           data_rng;
    logic [31:0]           req_rng;
    logic [1:0]            sync_cnt;
    int                    cycle;

    // one entry per begin pulse, consumed by each channel in turn
    buffer_pkg::buf_addr_t pending_start;
    buffer_pkg::buf_addr_t starts [64];
    int                    begin_cyc [64];
    int                    n_begin;
    int                    rd_idx [`BUF_NCHAN];
    int                    cnt [`BUF_NCHAN];
    buffer_pkg::buf_addr_t cur_start [`BUF_NCHAN];
    int                    done_count;
    int                    err_count;
    int                    check_count;
    int                    test_num;
    int                    test_base;

    event_buffer_top dut (
        .memclk        (memclk),
        .write_reset   (write_reset),
        .dat_i         (dat_i),
        .memclk_sync_i (memclk_sync_i),
        .req_data_i    (req_data_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .begin_o       (begin_o),
        .dat_o         (dat_o),
        .dat_valid_o   (dat_valid_o)
    );

    bind event_buffer_top event_buffer_checker u_checker (
        .memclk      (memclk),
        .write_reset (write_reset),
        .phase_i     (phase),
        .req_valid_i (req_valid_i),
        .req_ready_i (req_ready_o),
        .begin_i     (begin_o),
        .cmd_en_i    (cmd_chain[0].en),
        .dat_valid_i (dat_valid_o)
    );

    always #(clk_period / 2) memclk = ~memclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int error_total();
        return err_count + dut.u_checker.fail_count;
    endfunction

    // the shadow takes dat_i before this edge's new drive lands
    always @(posedge memclk) begin
        for (int c = 0; c < `BUF_NCHAN; c++) begin
            shadow[c][wr_ptr] = dat_i[c];
            for (int s = 0; s < `BUF_NSAMP; s++) begin
                data_rng = xorshift32(data_rng);
                dat_i[c].samples[s] <= buffer_pkg::sample_t'(data_rng);
            end
        end
        wr_ptr        <= write_reset ? '0 : wr_ptr + 1'b1;
        memclk_sync_i <= (sync_cnt == 2'd3);
        sync_cnt      <= sync_cnt + 1'b1;
        cycle         <= cycle + 1;
    end

    // outputs are sampled on the falling edge where they are settled
    always @(negedge memclk) begin
        buffer_pkg::buf_addr_t rd_addr;
        int                    exp_cyc;
        assert (dut.write_addr === wr_ptr) else begin
            $display("** Error at time %0t: write address %0d, expected %0d",
                     $time, dut.write_addr, wr_ptr);
            err_count++;
        end
        if (write_reset) begin
            for (int c = 0; c < `BUF_NCHAN; c++) begin
                cnt[c]    = 0;
                rd_idx[c] = n_begin;
            end
        end else begin
            if (begin_o) begin
                starts[n_begin]    = pending_start;
                begin_cyc[n_begin] = cycle;
                n_begin++;
            end
            for (int c = 0; c < `BUF_NCHAN; c++) begin
                if (dat_valid_o[c]) begin
                    if (cnt[c] == 0) begin
                        cur_start[c] = starts[rd_idx[c]];
                        exp_cyc      = begin_cyc[rd_idx[c]] + 3 + 2 * c;
                        rd_idx[c]++;
                        assert (cycle == exp_cyc) else begin
                            $display("** Error at time %0t: channel %0d valid at cycle %0d, %s %0d",
                                     $time, c, cycle, "expected", exp_cyc);
                            err_count++;
                        end
                    end
                    rd_addr = cur_start[c] + buffer_pkg::buf_addr_t'(cnt[c]);
                    check_count++;
                    assert (dat_o[c].raw === shadow[c][rd_addr].raw) else begin
                        $display("** Error at time %0t: channel %0d offset %0d got %h %s %h",
                                 $time, c, cnt[c], dat_o[c].raw, "expected",
                                 shadow[c][rd_addr].raw);
                        err_count++;
                    end
                    cnt[c]++;
                end else if (cnt[c] != 0) begin
                    assert (cnt[c] == `BUF_RDLEN) else begin
                        $display("** Error at time %0t: channel %0d read %0d words, expected %0d",
                                 $time, c, cnt[c], `BUF_RDLEN);
                        err_count++;
                    end
                    cnt[c] = 0;
                    if (c == `BUF_NCHAN - 1) begin
                        done_count++;
                    end
                end
            end
        end
    end

    task automatic apply_reset();
        @(posedge memclk);
        write_reset <= 1'b1;
        repeat (16) @(posedge memclk);
        write_reset <= 1'b0;
    endtask

    // keep enough written words below the pointer for a full readout
    task automatic wait_write_depth();
        while (wr_ptr < 128) @(negedge memclk);
    endtask

    task automatic wait_write_ptr(input buffer_pkg::buf_addr_t target);
        while (wr_ptr != target) @(negedge memclk);
    endtask

    task automatic wait_done(input int goal);
        while (done_count < goal) @(negedge memclk);
    endtask

    // start well behind the write pointer so the data read is settled
    task automatic make_request(input logic [1:0] low, input logic [hi_bits-1:0] hi,
                                output logic [`BUF_ADDRBITS-1:0] req);
        buffer_pkg::buf_addr_t base;
        req_rng = xorshift32(req_rng);
        base    = wr_ptr - buffer_pkg::buf_addr_t'(margin)
                  - buffer_pkg::buf_addr_t'(req_rng % 32);
        req     = {hi, base[`BUF_ADDRLEN-1:2], low};
    endtask

    // valid stays high on return so a following request can chain onto it
    task automatic send_request(input logic [`BUF_ADDRBITS-1:0] req);
        logic taken;
        @(posedge memclk);
        req_data_i  <= req;
        req_valid_i <= 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge memclk);
            taken = req_ready_o;
            @(posedge memclk);
        end
        pending_start = buffer_pkg::buf_addr_t'(req) & ~buffer_pkg::buf_addr_t'(3);
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = error_total() - test_base;
        test_num++;
        $display("test %0d %s: %s", test_num, name, (errs == 0) ? "ok" : "failed");
        test_base = error_total();
    endtask

    initial begin
        logic [`BUF_ADDRBITS-1:0] req;
        buffer_pkg::buf_addr_t    wrap_addr;
        int                       goal;
        memclk        = 1'b0;
        write_reset   = 1'b1;
        dat_i         = '0;
        memclk_sync_i = 1'b0;
        req_data_i    = '0;
        req_valid_i   = 1'b0;
        data_rng      = 32'd27435;
        req_rng       = 32'd27435;
        sync_cnt      = 2'd0;
        cycle         = 0;
        n_begin       = 0;
        done_count    = 0;
        err_count     = 0;
        check_count   = 0;
        test_num      = 0;
        test_base     = 0;
        for (int c = 0; c < `BUF_NCHAN; c++) begin
            cnt[c]    = 0;
            rd_idx[c] = 0;
        end
        repeat (16) @(posedge memclk);
        write_reset <= 1'b0;

        wait_write_depth();
        goal = done_count + 1;
        make_request(2'b00, '0, req);
        send_request(req);
        req_valid_i <= 1'b0;
        wait_done(goal);
        finish_test("aligned start");

        goal = done_count + 1;
        make_request(2'b11, '0, req);
        send_request(req);
        req_valid_i <= 1'b0;
        wait_done(goal);
        finish_test("unaligned start");

        goal = done_count + 1;
        make_request(2'b01, '1, req);
        send_request(req);
        req_valid_i <= 1'b0;
        wait_done(goal);
        finish_test("high request bits");

        // start twelve words below the top so the readout wraps to zero
        wrap_addr = buffer_pkg::buf_addr_t'(depth - 12);
        wait_write_ptr(wrap_addr + buffer_pkg::buf_addr_t'(margin + 4));
        goal = done_count + 1;
        send_request({2'b10, wrap_addr[`BUF_ADDRLEN-1:2], 2'b10});
        req_valid_i <= 1'b0;
        wait_done(goal);
        finish_test("wrap at top");

        goal = done_count + 2;
        make_request(2'b00, '0, req);
        send_request(req);
        make_request(2'b10, '0, req);
        send_request(req);
        req_valid_i <= 1'b0;
        wait_done(goal);
        finish_test("held request");

        make_request(2'b00, '0, req);
        send_request(req);
        req_valid_i <= 1'b0;
        while (!dat_valid_o[1]) @(negedge memclk);
        apply_reset();
        wait_write_depth();
        goal = done_count + 1;
        make_request(2'b01, '0, req);
        send_request(req);
        req_valid_i <= 1'b0;
        wait_done(goal);
        finish_test("reset mid readout");

        repeat (4) @(posedge memclk);
        $display("tests %0d, data checks %0d, failures %0d",
                 test_num, check_count, error_total());
        if (error_total() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // limit scales with the number of tests and the readout length
    initial begin
        #(n_tests * test_cycles * clk_period * 2);
        $display("timeout: the tests did not finish within %0d ns",
                 n_tests * test_cycles * clk_period * 2);
        $display("Errors found");
        $finish;
    end

endmodule
